/* build.f */
verilog/dsp_pkg.sv
verilog/lane_delay_line.sv
verilog/ffe_stage.sv
verilog/slicer_stage.sv
verilog/mlsd_check_stage.sv
verilog/dsp_backend.sv
verification/tb_clock_gen.sv
verification/tb_dsp_backend.sv

/* verification/tb_dsp_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dsp_backend;
	import dsp_pkg::*;

	localparam int LANES = 4;
	localparam int RESET_CYCLES = 3;
	localparam int RESET_WORDS = 6;
	localparam int SEG_WORDS = 12;
	localparam int LONG_WORDS = 300;
	localparam int LONG_SEG = 50;
	localparam int DRAIN_WORDS = 6;
	// identity, cross-lane and flag phases use 4, 6 and 6 segments.
	localparam int TOTAL_WORDS = RESET_WORDS + 16 * SEG_WORDS + LONG_WORDS + DRAIN_WORDS;
	localparam int CYCLE_LIMIT = RESET_CYCLES + TOTAL_WORDS + 20;
	// the change edge and the four after it mix old and new settings.
	localparam int SETTLE_CYCLES = 5;
	localparam int EST_HI = 2**(EST_W-1) - 1;
	localparam int EST_LO = -(2**(EST_W-1));

	logic clk;
	logic rst_n;
	logic [LANES*CODE_W-1:0] codes;
	logic [FFE_TAPS*WEIGHT_W-1:0] weight;
	logic [SHIFT_W-1:0] ffe_shift;
	logic signed [EST_W-1:0] thresh;
	logic signed [H_W-1:0] h0;
	logic signed [H_W-1:0] h1;
	logic [LANES*EST_W-1:0] estimates;
	logic [LANES-1:0] bits;
	logic [LANES-1:0] flags;

	logic [31:0] lfsr_state = 32'hec33;
	logic [LANES*CODE_W-1:0] hist [$];
	int settle = 0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	tb_clock_gen #(
		.PERIOD       (4),
		.RESET_CYCLES (RESET_CYCLES)
	) i_clock_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	dsp_backend #(
		.LANES (LANES)
	) i_dut (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.codes_i     (codes),
		.weight_i    (weight),
		.ffe_shift_i (ffe_shift),
		.thresh_i    (thresh),
		.h0_i        (h0),
		.h1_i        (h1),
		.estimates_o (estimates),
		.bits_o      (bits),
		.flags_o     (flags)
	);

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [LANES*CODE_W-1:0] random_word();
		logic [LANES*CODE_W-1:0] w;
		for (int l = 0; l < LANES; l++) begin
			w[l*CODE_W +: CODE_W] = CODE_W'(rand_bits(CODE_W));
		end
		return w;
	endfunction

	// stream sample k, lane-major, zero before the first word.
	function automatic int code_at(input int k);
		logic [LANES*CODE_W-1:0] w;
		if (k < 0) begin
			return 0;
		end
		w = hist[k / LANES];
		return int'($signed(w[(k % LANES)*CODE_W +: CODE_W]));
	endfunction

	function automatic int est_at(input int k);
		int sum;
		int w;
		sum = 0;
		for (int t = 0; t < FFE_TAPS; t++) begin
			w = int'($signed(weight[t*WEIGHT_W +: WEIGHT_W]));
			sum += w * code_at(k - t);
		end
		sum = sum >>> ffe_shift;
		if (sum > EST_HI) begin
			return EST_HI;
		end
		if (sum < EST_LO) begin
			return EST_LO;
		end
		return sum;
	endfunction

	function automatic int bit_at(input int k);
		if (k < 0) begin
			return 0;
		end
		return (est_at(k) >= int'(thresh)) ? 1 : 0;
	endfunction

	// distance of codes k and k+1 from the two-tap channel for one bit pattern.
	function automatic int hyp_error(input int c_k, input int c_next,
		input int b_prev, input int b_k, input int b_next);
		int g0;
		int g1;
		int e0;
		int e1;
		g0 = int'(h0);
		g1 = int'(h1);
		e0 = c_k - (g0 * (b_k != 0 ? 1 : -1) + g1 * (b_prev != 0 ? 1 : -1));
		e1 = c_next - (g0 * (b_next != 0 ? 1 : -1) + g1 * (b_k != 0 ? 1 : -1));
		if (e0 < 0) begin
			e0 = -e0;
		end
		if (e1 < 0) begin
			e1 = -e1;
		end
		return e0 + e1;
	endfunction

	function automatic int flag_at(input int k);
		int bk;
		int err_kept;
		int err_flip;
		bk = bit_at(k);
		err_kept = hyp_error(code_at(k), code_at(k + 1), bit_at(k - 1), bk, bit_at(k + 1));
		err_flip = hyp_error(code_at(k), code_at(k + 1), bit_at(k - 1), 1 - bk,
			bit_at(k + 1));
		return (err_flip < err_kept) ? 1 : 0;
	endfunction

	function automatic logic [LANES*EST_W-1:0] exp_estimates(input int n);
		logic [LANES*EST_W-1:0] w;
		w = '0;
		if (n >= 0) begin
			for (int l = 0; l < LANES; l++) begin
				w[l*EST_W +: EST_W] = EST_W'(est_at(n * LANES + l));
			end
		end
		return w;
	endfunction

	function automatic logic [LANES-1:0] exp_bits(input int n);
		logic [LANES-1:0] w;
		w = '0;
		if (n >= 0) begin
			for (int l = 0; l < LANES; l++) begin
				w[l] = bit_at(n * LANES + l) != 0;
			end
		end
		return w;
	endfunction

	function automatic logic [LANES-1:0] exp_flags(input int n);
		logic [LANES-1:0] w;
		w = '0;
		if (n >= 0) begin
			for (int l = 0; l < LANES; l++) begin
				w[l] = flag_at(n * LANES + l) != 0;
			end
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		checks++;
		if (act_val !== exp_val) begin
			errors++;
			$display("MISMATCH %s: expected %0h, got %0h at %0t ns", name, exp_val, act_val,
				$time);
		end
	endtask

	task automatic check_zero();
		check_value("estimates_o", '0, estimates);
		check_value("bits_o", '0, bits);
		check_value("flags_o", '0, flags);
	endtask

	task automatic send_word(input logic [LANES*CODE_W-1:0] w);
		@(negedge clk);
		codes = w;
		hist.push_back(w);
	endtask

	task automatic send_random_words(input int n);
		repeat (n) begin
			send_word(random_word());
		end
	endtask

	task automatic set_config(input logic [WEIGHT_W-1:0] w0, w1, w2,
		input logic [SHIFT_W-1:0] sh, input logic [EST_W-1:0] th,
		input logic [H_W-1:0] g0, g1);
		weight = {w2, w1, w0};
		ffe_shift = sh;
		thresh = th;
		h0 = g0;
		h1 = g1;
		settle = SETTLE_CYCLES;
	endtask

	task automatic random_config();
		set_config(WEIGHT_W'(rand_bits(WEIGHT_W)), WEIGHT_W'(rand_bits(WEIGHT_W)),
			WEIGHT_W'(rand_bits(WEIGHT_W)), SHIFT_W'(rand_bits(SHIFT_W)),
			EST_W'(rand_bits(EST_W)), H_W'(rand_bits(H_W)), H_W'(rand_bits(H_W)));
	endtask

	// estimates lag the newest word by 1, bits and flags by 4.
	always @(posedge clk) begin : compare
		int m;
		if (rst_n && hist.size() > 0) begin
			m = hist.size() - 1;
			if (settle > 0) begin
				settle--;
			end else begin
				check_value("estimates_o", exp_estimates(m - 1), estimates);
				check_value("bits_o", exp_bits(m - 4), bits);
				check_value("flags_o", exp_flags(m - 4), flags);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			errors++;
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		codes = '0;
		// zero history slices to zero bits and raises no flags.
		weight = '0;
		ffe_shift = '0;
		thresh = 10'sd1;
		h0 = '0;
		h1 = '0;

		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#1;
			check_zero();
		end
		repeat (RESET_WORDS) begin
			send_word('0);
			check_zero();
		end

		// identity ffe, several thresholds.
		set_config(8'h01, 8'h00, 8'h00, 4'd0, 10'h3d8, 8'h00, 8'h00);
		send_random_words(SEG_WORDS);
		set_config(8'h01, 8'h00, 8'h00, 4'd0, 10'h000, 8'h00, 8'h00);
		send_random_words(SEG_WORDS);
		set_config(8'h01, 8'h00, 8'h00, 4'd0, 10'd25, 8'h00, 8'h00);
		send_random_words(SEG_WORDS);
		set_config(8'h01, 8'h00, 8'h00, 4'd0, EST_W'(rand_bits(EST_W)), 8'h00, 8'h00);
		send_random_words(SEG_WORDS);

		// lanes 0 and 1 reach into the previous word.
		set_config(8'h00, 8'h00, 8'h01, 4'd0, 10'h000, 8'h00, 8'h00);
		send_random_words(SEG_WORDS);
		set_config(8'h00, 8'h01, 8'h00, 4'd0, 10'h000, 8'h00, 8'h00);
		send_random_words(SEG_WORDS);
		// large weights clip to both rails.
		set_config(8'h7f, 8'h7f, 8'h7f, 4'd0, 10'h000, 8'h00, 8'h00);
		send_random_words(SEG_WORDS);
		set_config(8'h80, 8'h7f, 8'h80, 4'd1, 10'h000, 8'h00, 8'h00);
		send_random_words(SEG_WORDS);
		repeat (2) begin
			set_config(WEIGHT_W'(rand_bits(WEIGHT_W)), WEIGHT_W'(rand_bits(WEIGHT_W)),
				WEIGHT_W'(rand_bits(WEIGHT_W)), SHIFT_W'(rand_bits(SHIFT_W)),
				10'h000, 8'h00, 8'h00);
			send_random_words(SEG_WORDS);
		end

		// sequence check, first without a post-cursor.
		// small positive codes slice low, so flipping them can fit better.
		set_config(8'h01, 8'h00, 8'h00, 4'd0, 10'd25, 8'd20, 8'h00);
		send_random_words(SEG_WORDS);
		set_config(8'h01, 8'h00, 8'h00, 4'd0, 10'd25, H_W'(rand_bits(H_W)), 8'h00);
		send_random_words(SEG_WORDS);
		repeat (4) begin
			set_config(8'h01, 8'h00, 8'h00, 4'd0, 10'h000, H_W'(rand_bits(H_W)),
				H_W'(rand_bits(H_W)));
			send_random_words(SEG_WORDS);
		end

		repeat (LONG_WORDS / LONG_SEG) begin
			random_config();
			send_random_words(LONG_SEG);
		end

		repeat (DRAIN_WORDS) begin
			send_word('0);
		end
		@(posedge clk);
		#1;

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule : tb_dsp_backend

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 4,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD / 2);
			clk_o = ~clk_o;
		end
	end

	// release on a falling edge, clear of the sampling edge.
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule : tb_clock_gen

`default_nettype wire

/* verilog/dsp_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module dsp_backend #(
	parameter int LANES = dsp_pkg::DEFAULT_LANES
) (
	input wire logic clk,
	input wire logic rst_n_i,

	input wire logic [LANES*dsp_pkg::CODE_W-1:0] codes_i,

	input wire logic [dsp_pkg::FFE_TAPS*dsp_pkg::WEIGHT_W-1:0] weight_i,
	input wire logic [dsp_pkg::SHIFT_W-1:0] ffe_shift_i,
	input wire logic signed [dsp_pkg::EST_W-1:0] thresh_i,
	input wire logic signed [dsp_pkg::H_W-1:0] h0_i,
	input wire logic signed [dsp_pkg::H_W-1:0] h1_i,

	output logic [LANES*dsp_pkg::EST_W-1:0] estimates_o,
	output logic [LANES-1:0] bits_o,
	output logic [LANES-1:0] flags_o
);
	import dsp_pkg::*;

	logic [LANES*CODE_W-1:0] prev_codes;
	logic [LANES*CODE_W-1:0] align_codes;
	logic [LANES-1:0] sliced_bits;

	lane_delay_line #(
		.payload_t (logic [LANES*CODE_W-1:0]),
		.DEPTH     (1)
	) i_ffe_hist (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (codes_i),
		.q_o     (prev_codes),
		.tap_o   ()
	);

	// ffe and slicer take two cycles, so the checker sees codes matching its bits.
	lane_delay_line #(
		.payload_t (logic [LANES*CODE_W-1:0]),
		.DEPTH     (2)
	) i_code_align (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (codes_i),
		.q_o     (align_codes),
		.tap_o   ()
	);

	ffe_stage #(
		.LANES (LANES)
	) i_ffe (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.codes_i      (codes_i),
		.prev_codes_i (prev_codes),
		.weight_i     (weight_i),
		.ffe_shift_i  (ffe_shift_i),
		.est_o        (estimates_o)
	);

	slicer_stage #(
		.LANES (LANES)
	) i_slicer (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.est_i    (estimates_o),
		.thresh_i (thresh_i),
		.bits_o   (sliced_bits)
	);

	mlsd_check_stage #(
		.LANES (LANES)
	) i_mlsd_check (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.bits_i  (sliced_bits),
		.codes_i (align_codes),
		.h0_i    (h0_i),
		.h1_i    (h1_i),
		.bits_o  (bits_o),
		.flags_o (flags_o)
	);

endmodule : dsp_backend

`default_nettype wire

/* verilog/mlsd_check_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mlsd_check_stage #(
	parameter int LANES = dsp_pkg::DEFAULT_LANES
) (
	input wire logic clk,
	input wire logic rst_n_i,

	input wire logic [LANES-1:0] bits_i,
	input wire logic [LANES*dsp_pkg::CODE_W-1:0] codes_i,

	input wire logic signed [dsp_pkg::H_W-1:0] h0_i,
	input wire logic signed [dsp_pkg::H_W-1:0] h1_i,

	output logic [LANES-1:0] bits_o,
	output logic [LANES-1:0] flags_o
);
	import dsp_pkg::*;

	// room for code minus the largest expectation, h0 plus h1.
	localparam int DIFF_W = ((CODE_W > H_W) ? CODE_W : H_W) + 3;
	localparam int ERR_W = DIFF_W + 1;

	logic [LANES-1:0] bits_hist;
	logic [LANES*CODE_W-1:0] codes_hist;

	// bit k-1, the word under test, then bit k+1 from the next word.
	logic bit_win [LANES+2];
	logic signed [CODE_W-1:0] code_win [LANES+1];

	logic [ERR_W-1:0] err_a [LANES];
	logic [ERR_W-1:0] err_b [LANES];
	logic [LANES-1:0] flags_d;

	function automatic logic signed [DIFF_W-1:0] sym_term(input logic b,
		input logic signed [H_W-1:0] h);
		return b ? DIFF_W'(h) : -DIFF_W'(h);
	endfunction

	function automatic logic [ERR_W-1:0] abs_err(input logic signed [CODE_W-1:0] code,
		input logic signed [DIFF_W-1:0] exp_val);
		logic signed [DIFF_W-1:0] d;
		d = DIFF_W'(code) - exp_val;
		return d[DIFF_W-1] ? ERR_W'(-d) : ERR_W'(d);
	endfunction

	// error over samples k and k+1 for one choice of bit k.
	function automatic logic [ERR_W-1:0] seq_err(
		input logic signed [CODE_W-1:0] c_cur, c_next,
		input logic b_prev, b_cur, b_next,
		input logic signed [H_W-1:0] h0, h1);
		return abs_err(c_cur, sym_term(b_cur, h0) + sym_term(b_prev, h1))
			+ abs_err(c_next, sym_term(b_next, h0) + sym_term(b_cur, h1));
	endfunction

	lane_delay_line #(
		.payload_t (logic [LANES-1:0]),
		.DEPTH     (1)
	) i_bit_hist (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (bits_i),
		.q_o     (bits_hist),
		.tap_o   ()
	);

	lane_delay_line #(
		.payload_t (logic [LANES*CODE_W-1:0]),
		.DEPTH     (1)
	) i_code_hist (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (codes_i),
		.q_o     (codes_hist),
		.tap_o   ()
	);

	// the last bit of the word before sits in the output register.
	always_comb begin
		bit_win[0] = bits_o[LANES-1];
		bit_win[LANES+1] = bits_i[0];
		code_win[LANES] = codes_i[CODE_W-1:0];
		for (int i = 0; i < LANES; i++) begin
			bit_win[i+1] = bits_hist[i];
			code_win[i] = codes_hist[i*CODE_W +: CODE_W];
		end
	end

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			err_a[l] = seq_err(code_win[l], code_win[l+1],
				bit_win[l], bit_win[l+1], bit_win[l+2], h0_i, h1_i);
			err_b[l] = seq_err(code_win[l], code_win[l+1],
				bit_win[l], ~bit_win[l+1], bit_win[l+2], h0_i, h1_i);
			flags_d[l] = err_b[l] < err_a[l];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			bits_o <= '0;
			flags_o <= '0;
		end else begin
			bits_o <= bits_hist;
			flags_o <= flags_d;
		end
	end

	// with no channel both hypotheses tie.
	a_no_flag_flat: assert property (@(posedge clk) disable iff (!rst_n_i)
		($past(h0_i) == '0 && $past(h1_i) == '0) |-> flags_o == '0);

endmodule : mlsd_check_stage

`default_nettype wire

/* verilog/slicer_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module slicer_stage #(
	parameter int LANES = dsp_pkg::DEFAULT_LANES
) (
	input wire logic clk,
	input wire logic rst_n_i,

	input wire logic [LANES*dsp_pkg::EST_W-1:0] est_i,
	input wire logic signed [dsp_pkg::EST_W-1:0] thresh_i,

	output logic [LANES-1:0] bits_o
);
	import dsp_pkg::*;

	// bit is 1 at or above the threshold.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			bits_o <= '0;
		end else begin
			for (int l = 0; l < LANES; l++) begin
				bits_o[l] <= $signed(est_i[l*EST_W +: EST_W]) >= thresh_i;
			end
		end
	end

	a_bits_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(bits_o));

endmodule : slicer_stage

`default_nettype wire

/* verilog/ffe_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ffe_stage #(
	parameter int LANES = dsp_pkg::DEFAULT_LANES
) (
	input wire logic clk,
	input wire logic rst_n_i,

	input wire logic [LANES*dsp_pkg::CODE_W-1:0] codes_i,
	input wire logic [LANES*dsp_pkg::CODE_W-1:0] prev_codes_i,

	input wire logic [dsp_pkg::FFE_TAPS*dsp_pkg::WEIGHT_W-1:0] weight_i,
	input wire logic [dsp_pkg::SHIFT_W-1:0] ffe_shift_i,

	output logic [LANES*dsp_pkg::EST_W-1:0] est_o
);
	import dsp_pkg::*;

	// full precision of one tap sum.
	localparam int SUM_W = CODE_W + WEIGHT_W + $clog2(FFE_TAPS);

	localparam logic signed [EST_W-1:0] EST_MAX = {1'b0, {(EST_W-1){1'b1}}};
	localparam logic signed [EST_W-1:0] EST_MIN = {1'b1, {(EST_W-1){1'b0}}};
	localparam logic signed [SUM_W-1:0] SUM_MAX = SUM_W'(EST_MAX);
	localparam logic signed [SUM_W-1:0] SUM_MIN = SUM_W'(EST_MIN);

	logic signed [CODE_W-1:0] window [2*LANES];
	logic signed [SUM_W-1:0] sum [LANES];
	logic signed [SUM_W-1:0] shifted [LANES];
	logic signed [EST_W-1:0] sat [LANES];
	logic [LANES-1:0] ovf_pos;
	logic [LANES-1:0] ovf_neg;

	// previous word first, so lanes 0 and 1 can look back across the boundary.
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			window[i] = prev_codes_i[i*CODE_W +: CODE_W];
			window[LANES+i] = codes_i[i*CODE_W +: CODE_W];
		end
	end

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			sum[l] = '0;
			// tap t weights the sample t positions earlier.
			for (int t = 0; t < FFE_TAPS; t++) begin
				sum[l] = sum[l]
					+ $signed(weight_i[t*WEIGHT_W +: WEIGHT_W]) * window[LANES+l-t];
			end
			shifted[l] = sum[l] >>> ffe_shift_i;
			ovf_pos[l] = shifted[l] > SUM_MAX;
			ovf_neg[l] = shifted[l] < SUM_MIN;
			if (ovf_pos[l]) begin
				sat[l] = EST_MAX;
			end else if (ovf_neg[l]) begin
				sat[l] = EST_MIN;
			end else begin
				sat[l] = shifted[l][EST_W-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			est_o <= '0;
		end else begin
			for (int l = 0; l < LANES; l++) begin
				est_o[l*EST_W +: EST_W] <= sat[l];
			end
		end
	end

	// a clipped lane lands on the rail of its own sign one cycle later.
	for (genvar l = 0; l < LANES; l++) begin : g_sat_check
		a_sat_pos: assert property (@(posedge clk) disable iff (!rst_n_i)
			ovf_pos[l] |=> $signed(est_o[l*EST_W +: EST_W]) == EST_MAX);
		a_sat_neg: assert property (@(posedge clk) disable iff (!rst_n_i)
			ovf_neg[l] |=> $signed(est_o[l*EST_W +: EST_W]) == EST_MIN);
	end

endmodule : ffe_stage

`default_nettype wire

/* verilog/lane_delay_line.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_delay_line #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1
) (
	input wire logic clk,
	input wire logic rst_n_i,

	input wire payload_t d_i,

	output payload_t q_o,
	output payload_t tap_o [DEPTH]
);

	// tap 0 is the most recent word.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				tap_o[i] <= '0;
			end
		end else begin
			tap_o[0] <= d_i;
			for (int i = 1; i < DEPTH; i++) begin
				tap_o[i] <= tap_o[i-1];
			end
		end
	end

	assign q_o = tap_o[DEPTH-1];

	if (DEPTH < 1) begin : g_depth_check
		$error("lane_delay_line needs DEPTH of at least 1");
	end

endmodule : lane_delay_line

`default_nettype wire

/* verilog/dsp_pkg.sv */
`default_nettype none

package dsp_pkg;

	// signed adc code per lane.
	localparam int CODE_W = 8;

	// equalized estimate after shift and saturation.
	localparam int EST_W = 10;

	// signed ffe weight.
	localparam int WEIGHT_W = 8;

	// three taps reach back at most one whole word for LANES of 2 or more.
	localparam int FFE_TAPS = 3;

	// right shift applied to the tap sum.
	localparam int SHIFT_W = 4;

	// signed channel estimate taps h0 and h1.
	localparam int H_W = 8;

	// lanes per word.
	localparam int DEFAULT_LANES = 4;

endpackage : dsp_pkg

`default_nettype wire
